// File: hdl/trace_pkg.sv
//////////////////////////////
// Widths and encodings shared by the tracer; only ten machine CSRs are tracked
// CSR slot order must match the address list order
//////////////////////////////

package trace_pkg;

    // Architectural register width
    localparam int XLEN       = 32;

    // General register file
    localparam int NUM_XREGS  = 32;
    localparam int XREG_AW    = $clog2(NUM_XREGS);

    // Privilege mode field
    localparam int MODE_W     = 2;

    // Tracked CSR slots
    localparam int NUM_CSR    = 10;
    localparam int CSR_AW     = 12;
    localparam int CSR_SLOT_W = $clog2(NUM_CSR);

    //////////////////////////////
    // Tracked CSR addresses
    //////////////////////////////

    // Machine info registers first, then trap setup and handling
    typedef enum logic [CSR_AW-1:0] {
        CSR_MISA      = 12'h301,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14,
        CSR_MSTATUS   = 12'h300,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342
    } csr_addr_e;

    // Bit position in the CSR flag vector, same order as above
    typedef enum logic [CSR_SLOT_W-1:0] {
        SLOT_MISA      = 4'd0,
        SLOT_MVENDORID = 4'd1,
        SLOT_MARCHID   = 4'd2,
        SLOT_MIMPID    = 4'd3,
        SLOT_MHARTID   = 4'd4,
        SLOT_MSTATUS   = 4'd5,
        SLOT_MIE       = 4'd6,
        SLOT_MTVEC     = 4'd7,
        SLOT_MEPC      = 4'd8,
        SLOT_MCAUSE    = 4'd9
    } csr_slot_e;

    //////////////////////////////
    // Trace control states
    //////////////////////////////

    typedef enum logic [1:0] {
        TRACE_OFF     = 2'd0,
        TRACE_RUN     = 2'd1,
        TRACE_HALTED  = 2'd2
    } trace_state_e;

endpackage

// File: hdl/trace_ctrl_fsm.sv
//////////////////////////////
// Retirements are only accepted in the run state with the enable level high
// A halting record parks the machine until the enable level drops
//////////////////////////////

`timescale 1ns/1ns

module trace_ctrl_fsm import trace_pkg::*; (
    input  logic clk_i,
    input  logic reset_i,
    input  logic trace_en_i,
    input  logic rvfi_valid_i,
    input  logic rvfi_halt_i,
    output logic capture_o,
    output logic valid_o
);

    trace_state_e state_q;
    trace_state_e state_d;

    // Accept strobe, same cycle as the retirement
    assign capture_o = (state_q == TRACE_RUN) && trace_en_i && rvfi_valid_i;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRACE_OFF: begin
                if (trace_en_i) begin
                    state_d = TRACE_RUN;
                end
            end
            TRACE_RUN: begin
                // Enable drop wins over a halt in the same cycle
                if (!trace_en_i) begin
                    state_d = TRACE_OFF;
                end else if (capture_o && rvfi_halt_i) begin
                    state_d = TRACE_HALTED;
                end
            end
            TRACE_HALTED: begin
                // Only way out is a disable
                if (!trace_en_i) begin
                    state_d = TRACE_OFF;
                end
            end
            default: begin
                state_d = TRACE_OFF;
            end
        endcase
    end

    // State and record-valid registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= TRACE_OFF;
            valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // One pulse per accepted retirement
            valid_o <= capture_o;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Record pulse must trace back to an accepted retirement
    a_valid_follows_capture: assert property (
        @(posedge clk_i) disable iff (reset_i)
        valid_o |-> $past(capture_o)
    ) else $error("valid_o without capture in previous cycle");

    // Halted machine stays silent until disabled
    a_no_capture_halted: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (state_q == TRACE_HALTED) |-> !capture_o
    ) else $error("capture_o raised while halted");

endmodule

// File: hdl/retire_order_counter.sv
//////////////////////////////
// Order number wraps silently at ORDER_W bits
//////////////////////////////

`timescale 1ns/1ns

module retire_order_counter import trace_pkg::*; #(
    parameter int ORDER_W = 64
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               capture_i,
    output logic [ORDER_W-1:0] order_o
);

    // Number to hand out on the next accepted record
    logic [ORDER_W-1:0] next_q;

    // Value shown alongside valid_o
    logic [ORDER_W-1:0] order_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            next_q  <= '0;
            order_q <= '0;
        end else if (capture_i) begin
            // Show the pre-increment count, then advance
            order_q <= next_q;
            next_q  <= next_q + 1'b1;
        end
    end

    assign order_o = order_q;

endmodule

// File: hdl/retire_record_reg.sv
//////////////////////////////
// Fields of an accepted retirement, held until the next capture
// Write data slots are only meaningful while the matching flag is set
//////////////////////////////

`timescale 1ns/1ns

module retire_record_reg import trace_pkg::*; (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            capture_i,
    input  logic [XLEN-1:0]                 rvfi_insn_i,
    input  logic [XLEN-1:0]                 rvfi_pc_rdata_i,
    input  logic [XLEN-1:0]                 rvfi_pc_wdata_i,
    input  logic [XREG_AW-1:0]              rvfi_rd_addr_i,
    input  logic [XLEN-1:0]                 rvfi_rd_wdata_i,
    input  logic                            rvfi_trap_i,
    input  logic                            rvfi_intr_i,
    input  logic                            rvfi_halt_i,
    input  logic [MODE_W-1:0]               rvfi_mode_i,
    output logic [XLEN-1:0]                 insn_o,
    output logic [XLEN-1:0]                 pc_rdata_o,
    output logic [XLEN-1:0]                 pc_wdata_o,
    output logic                            trap_o,
    output logic                            intr_o,
    output logic                            halt_o,
    output logic [MODE_W-1:0]               mode_o,
    output logic [NUM_XREGS-1:0]            x_wb_o,
    output logic [NUM_XREGS-1:0][XLEN-1:0]  x_wdata_o
);

    // Decoded writeback, before the register stage
    logic [NUM_XREGS-1:0]           x_wb_d;
    logic [NUM_XREGS-1:0][XLEN-1:0] x_wdata_d;

    //////////////////////////////
    // Destination decode
    //////////////////////////////

    always_comb begin
        x_wb_d    = '0;
        x_wdata_d = '0;
        // x0 is hardwired zero, never reported as written
        if (rvfi_rd_addr_i != '0) begin
            x_wb_d[rvfi_rd_addr_i]    = 1'b1;
            x_wdata_d[rvfi_rd_addr_i] = rvfi_rd_wdata_i;
        end
    end

    // Flags and status bits
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            x_wb_o <= '0;
            trap_o <= 1'b0;
            intr_o <= 1'b0;
            halt_o <= 1'b0;
        end else if (capture_i) begin
            x_wb_o <= x_wb_d;
            trap_o <= rvfi_trap_i;
            intr_o <= rvfi_intr_i;
            halt_o <= rvfi_halt_i;
        end
    end

    // Payload fields
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            insn_o     <= rvfi_insn_i;
            pc_rdata_o <= rvfi_pc_rdata_i;
            pc_wdata_o <= rvfi_pc_wdata_i;
            mode_o     <= rvfi_mode_i;
            x_wdata_o  <= x_wdata_d;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // At most one destination per retirement, and never x0
    a_x_wb_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $onehot0(x_wb_o) && !x_wb_o[0]
    ) else $error("x_wb_o not one-hot or flags x0");

endmodule

// File: hdl/csr_writeback_map.sv
//////////////////////////////
// Only the ten tracked CSRs get slots; writes to any other address are dropped
// The CSR address is taken from instruction bits 31:20
//////////////////////////////

`timescale 1ns/1ns

module csr_writeback_map import trace_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          capture_i,
    input  logic                          rvfi_csr_wen_i,
    input  logic [XLEN-1:0]               rvfi_insn_i,
    input  logic [XLEN-1:0]               rvfi_csr_wdata_i,
    output logic [NUM_CSR-1:0]            csr_wb_o,
    output logic [NUM_CSR-1:0][XLEN-1:0]  csr_wdata_o
);

    // CSR field of the instruction
    csr_addr_e csr_addr;

    // Slot lookup result
    csr_slot_e csr_slot;
    logic      csr_hit;

    // Decoded flags and data
    logic [NUM_CSR-1:0]           csr_wb_d;
    logic [NUM_CSR-1:0][XLEN-1:0] csr_wdata_d;

    assign csr_addr = csr_addr_e'(rvfi_insn_i[31:20]);

    //////////////////////////////
    // Address to slot
    //////////////////////////////

    always_comb begin
        csr_slot = SLOT_MISA;
        csr_hit  = 1'b1;
        case (csr_addr)
            CSR_MISA:      csr_slot = SLOT_MISA;
            CSR_MVENDORID: csr_slot = SLOT_MVENDORID;
            CSR_MARCHID:   csr_slot = SLOT_MARCHID;
            CSR_MIMPID:    csr_slot = SLOT_MIMPID;
            CSR_MHARTID:   csr_slot = SLOT_MHARTID;
            CSR_MSTATUS:   csr_slot = SLOT_MSTATUS;
            CSR_MIE:       csr_slot = SLOT_MIE;
            CSR_MTVEC:     csr_slot = SLOT_MTVEC;
            CSR_MEPC:      csr_slot = SLOT_MEPC;
            CSR_MCAUSE:    csr_slot = SLOT_MCAUSE;
            // Untracked address
            default:       csr_hit  = 1'b0;
        endcase
    end

    // Flag and data for the matched slot only
    always_comb begin
        csr_wb_d    = '0;
        csr_wdata_d = '0;
        if (rvfi_csr_wen_i && csr_hit) begin
            csr_wb_d[csr_slot]    = 1'b1;
            csr_wdata_d[csr_slot] = rvfi_csr_wdata_i;
        end
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    // Flags cleared on reset, follow every capture
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            csr_wb_o <= '0;
        end else if (capture_i) begin
            csr_wb_o <= csr_wb_d;
        end
    end

    // Data slots
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            csr_wdata_o <= csr_wdata_d;
        end
    end

    // A single retirement writes one CSR at most
    a_csr_wb_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $onehot0(csr_wb_o)
    ) else $error("csr_wb_o has more than one flag set");

endmodule

// File: hdl/rvvi_tracer.sv
//////////////////////////////
// Records appear one cycle after the retirement strobe; no back-pressure
//////////////////////////////

`timescale 1ns/1ns

module rvvi_tracer import trace_pkg::*; #(
    parameter int ORDER_W = 64
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            trace_en_i,
    input  logic                            rvfi_valid_i,
    input  logic [XLEN-1:0]                 rvfi_insn_i,
    input  logic [XLEN-1:0]                 rvfi_pc_rdata_i,
    input  logic [XLEN-1:0]                 rvfi_pc_wdata_i,
    input  logic [XREG_AW-1:0]              rvfi_rd_addr_i,
    input  logic [XLEN-1:0]                 rvfi_rd_wdata_i,
    input  logic                            rvfi_csr_wen_i,
    input  logic [XLEN-1:0]                 rvfi_csr_wdata_i,
    input  logic                            rvfi_trap_i,
    input  logic                            rvfi_intr_i,
    input  logic                            rvfi_halt_i,
    input  logic [MODE_W-1:0]               rvfi_mode_i,
    output logic                            valid_o,
    output logic [ORDER_W-1:0]              order_o,
    output logic [XLEN-1:0]                 insn_o,
    output logic [XLEN-1:0]                 pc_rdata_o,
    output logic [XLEN-1:0]                 pc_wdata_o,
    output logic                            trap_o,
    output logic                            intr_o,
    output logic                            halt_o,
    output logic [MODE_W-1:0]               mode_o,
    output logic [NUM_XREGS-1:0]            x_wb_o,
    output logic [NUM_XREGS-1:0][XLEN-1:0]  x_wdata_o,
    output logic [NUM_CSR-1:0]              csr_wb_o,
    output logic [NUM_CSR-1:0][XLEN-1:0]    csr_wdata_o
);

    // Accept strobe shared by all capture stages
    logic capture;

    // Enable and halt control
    trace_ctrl_fsm u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .trace_en_i   (trace_en_i),
        .rvfi_valid_i (rvfi_valid_i),
        .rvfi_halt_i  (rvfi_halt_i),
        .capture_o    (capture),
        .valid_o      (valid_o)
    );

    // Record numbering
    retire_order_counter #(
        .ORDER_W (ORDER_W)
    ) u_order (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .capture_i (capture),
        .order_o   (order_o)
    );

    // Retirement fields and register writeback
    retire_record_reg u_record (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .capture_i       (capture),
        .rvfi_insn_i     (rvfi_insn_i),
        .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
        .rvfi_pc_wdata_i (rvfi_pc_wdata_i),
        .rvfi_rd_addr_i  (rvfi_rd_addr_i),
        .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
        .rvfi_trap_i     (rvfi_trap_i),
        .rvfi_intr_i     (rvfi_intr_i),
        .rvfi_halt_i     (rvfi_halt_i),
        .rvfi_mode_i     (rvfi_mode_i),
        .insn_o          (insn_o),
        .pc_rdata_o      (pc_rdata_o),
        .pc_wdata_o      (pc_wdata_o),
        .trap_o          (trap_o),
        .intr_o          (intr_o),
        .halt_o          (halt_o),
        .mode_o          (mode_o),
        .x_wb_o          (x_wb_o),
        .x_wdata_o       (x_wdata_o)
    );

    // Tracked CSR writeback
    csr_writeback_map u_csr (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .capture_i        (capture),
        .rvfi_csr_wen_i   (rvfi_csr_wen_i),
        .rvfi_insn_i      (rvfi_insn_i),
        .rvfi_csr_wdata_i (rvfi_csr_wdata_i),
        .csr_wb_o         (csr_wb_o),
        .csr_wdata_o      (csr_wdata_o)
    );

endmodule

// File: sim/tb_clock_gen.sv
//////////////////////////////
// 10 ns clock; reset drops 1 ns after the last reset edge
//////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

// File: sim/tb_rvvi_tracer.sv
//////////////////////////////
// Inputs change 1 ns after the rising edge; every cycle must pass through next_cycle
//////////////////////////////

`timescale 1ns/1ns

module tb_rvvi_tracer import trace_pkg::*; ();

    localparam int ORDER_W = 64;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Reset 4, tests at most 130 with the longest order gaps
    localparam int STIM_CYCLES    = 134;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    // misa, mvendorid, marchid, mimpid, mhartid, mstatus, mie, mtvec, mepc, mcause
    localparam logic [11:0] TRACKED_CSR [NUM_CSR] = '{
        12'h301, 12'hF11, 12'hF12, 12'hF13, 12'hF14,
        12'h300, 12'h304, 12'h305, 12'h341, 12'h342
    };

    typedef enum logic [1:0] {M_OFF, M_RUN, M_HALTED} model_state_e;

    // Expected view of one emitted record
    typedef struct packed {
        logic [ORDER_W-1:0]             order;
        logic [XLEN-1:0]                insn;
        logic [XLEN-1:0]                pc_rdata;
        logic [XLEN-1:0]                pc_wdata;
        logic                           trap;
        logic                           intr;
        logic                           halt;
        logic [MODE_W-1:0]              mode;
        logic [NUM_XREGS-1:0]           x_wb;
        logic [NUM_XREGS-1:0][XLEN-1:0] x_wdata;
        logic [NUM_CSR-1:0]             csr_wb;
        logic [NUM_CSR-1:0][XLEN-1:0]   csr_wdata;
    } record_t;

    logic clk;
    logic reset;

    // DUT inputs
    logic                trace_en;
    logic                rvfi_valid;
    logic [XLEN-1:0]     rvfi_insn;
    logic [XLEN-1:0]     rvfi_pc_rdata;
    logic [XLEN-1:0]     rvfi_pc_wdata;
    logic [XREG_AW-1:0]  rvfi_rd_addr;
    logic [XLEN-1:0]     rvfi_rd_wdata;
    logic                rvfi_csr_wen;
    logic [XLEN-1:0]     rvfi_csr_wdata;
    logic                rvfi_trap;
    logic                rvfi_intr;
    logic                rvfi_halt;
    logic [MODE_W-1:0]   rvfi_mode;

    // DUT outputs
    logic                           valid;
    logic [ORDER_W-1:0]             order;
    logic [XLEN-1:0]                insn;
    logic [XLEN-1:0]                pc_rdata;
    logic [XLEN-1:0]                pc_wdata;
    logic                           trap;
    logic                           intr;
    logic                           halt;
    logic [MODE_W-1:0]              mode;
    logic [NUM_XREGS-1:0]           x_wb;
    logic [NUM_XREGS-1:0][XLEN-1:0] x_wdata;
    logic [NUM_CSR-1:0]             csr_wb;
    logic [NUM_CSR-1:0][XLEN-1:0]   csr_wdata;

    // Reference model state
    record_t            exp_q[$];
    record_t            popped;
    record_t            ref_rec;
    logic               exp_valid = 1'b0;
    logic               have_rec  = 1'b0;
    model_state_e       model_state;
    logic [ORDER_W-1:0] order_cnt;
    logic [XLEN-1:0]    pc_model;
    logic [31:0]        lfsr_state;

    int errors     = 0;
    int tests_run  = 0;
    int rec_count  = 0;
    int cycle_count = 0;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rvvi_tracer u_dut (
        .clk_i (clk), .reset_i (reset), .trace_en_i (trace_en),
        .rvfi_valid_i (rvfi_valid), .rvfi_insn_i (rvfi_insn),
        .rvfi_pc_rdata_i (rvfi_pc_rdata), .rvfi_pc_wdata_i (rvfi_pc_wdata),
        .rvfi_rd_addr_i (rvfi_rd_addr), .rvfi_rd_wdata_i (rvfi_rd_wdata),
        .rvfi_csr_wen_i (rvfi_csr_wen), .rvfi_csr_wdata_i (rvfi_csr_wdata),
        .rvfi_trap_i (rvfi_trap), .rvfi_intr_i (rvfi_intr),
        .rvfi_halt_i (rvfi_halt), .rvfi_mode_i (rvfi_mode),
        .valid_o (valid), .order_o (order), .insn_o (insn),
        .pc_rdata_o (pc_rdata), .pc_wdata_o (pc_wdata),
        .trap_o (trap), .intr_o (intr), .halt_o (halt), .mode_o (mode),
        .x_wb_o (x_wb), .x_wdata_o (x_wdata),
        .csr_wb_o (csr_wb), .csr_wdata_o (csr_wdata)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) lfsr_state = lfsr_state ^ LFSR_TAPS;
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    function automatic logic [XREG_AW-1:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(XREG_AW);
        return r[XREG_AW-1:0];
    endfunction

    // Slot of a tracked CSR, -1 when untracked
    function automatic int csr_slot_of(input logic [11:0] addr);
        int slot;
        slot = -1;
        for (int i = 0; i < NUM_CSR; i++) begin
            if (TRACKED_CSR[i] == addr) slot = i;
        end
        return slot;
    endfunction

    // Record the tracer should show for the inputs now on the bus
    function automatic record_t build_record();
        record_t rec;
        int      slot;
        rec          = '0;
        rec.order    = order_cnt;
        rec.insn     = rvfi_insn;
        rec.pc_rdata = rvfi_pc_rdata;
        rec.pc_wdata = rvfi_pc_wdata;
        rec.trap     = rvfi_trap;
        rec.intr     = rvfi_intr;
        rec.halt     = rvfi_halt;
        rec.mode     = rvfi_mode;
        // x0 writes are never flagged
        if (rvfi_rd_addr != '0) begin
            rec.x_wb[rvfi_rd_addr]    = 1'b1;
            rec.x_wdata[rvfi_rd_addr] = rvfi_rd_wdata;
        end
        slot = csr_slot_of(rvfi_insn[31:20]);
        if (rvfi_csr_wen && slot >= 0) begin
            rec.csr_wb[slot]    = 1'b1;
            rec.csr_wdata[slot] = rvfi_csr_wdata;
        end
        return rec;
    endfunction

    // Apply the control rules to this cycle's inputs, then move to the next drive point
    task automatic next_cycle();
        logic accept;
        accept = (model_state == M_RUN) && trace_en && rvfi_valid;
        if (accept) begin
            exp_q.push_back(build_record());
            order_cnt = order_cnt + 64'd1;
        end
        case (model_state)
            M_OFF:   if (trace_en) model_state = M_RUN;
            M_RUN: begin
                if (!trace_en) model_state = M_OFF;
                else if (accept && rvfi_halt) model_state = M_HALTED;
            end
            default: if (!trace_en) model_state = M_OFF;
        endcase
        @(posedge clk);
        #1;
    endtask

    // One retirement strobe with random payload
    task automatic retire(input logic [XREG_AW-1:0] rd, input logic [XLEN-1:0] insn_word,
                          input logic csr_we, input logic halt_req);
        logic [31:0] flags;
        flags          = rand_bits(4);
        rvfi_valid     = 1'b1;
        rvfi_insn      = insn_word;
        rvfi_rd_addr   = rd;
        rvfi_rd_wdata  = rand_bits(32);
        rvfi_csr_wen   = csr_we;
        rvfi_csr_wdata = rand_bits(32);
        rvfi_pc_rdata  = pc_model;
        rvfi_pc_wdata  = pc_model + 32'd4;
        pc_model       = pc_model + 32'd4;
        rvfi_trap      = flags[0];
        rvfi_intr      = flags[1];
        rvfi_mode      = flags[3:2];
        rvfi_halt      = halt_req;
        next_cycle();
    endtask

    task automatic idle_cycles(input int n);
        rvfi_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        $display("test %s finished at %0t, %0d errors", name, $time, errors - errs_at_start);
    endtask

    //////////////////////////////
    // Reference model and checks
    //////////////////////////////

    // Record pushed before an edge is what the outputs show after it
    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
        end else if (exp_q.size() > 0) begin
            popped = exp_q.pop_front();
            ref_rec   <= popped;
            exp_valid <= 1'b1;
            have_rec  <= 1'b1;
            rec_count++;
        end else begin
            exp_valid <= 1'b0;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (reset) valid == exp_valid)
        else begin errors++; $display("FAILED at %0t: valid_o mismatch", $time); end

    a_order: assert property (@(posedge clk) disable iff (reset)
        have_rec |-> order == ref_rec.order)
        else begin errors++; $display("FAILED at %0t: order_o mismatch", $time); end

    a_fields: assert property (@(posedge clk) disable iff (reset)
        have_rec |-> (insn == ref_rec.insn && pc_rdata == ref_rec.pc_rdata
            && pc_wdata == ref_rec.pc_wdata && trap == ref_rec.trap
            && intr == ref_rec.intr && halt == ref_rec.halt && mode == ref_rec.mode))
        else begin errors++; $display("FAILED at %0t: retirement fields mismatch", $time); end

    a_xreg: assert property (@(posedge clk) disable iff (reset)
        have_rec |-> (x_wb == ref_rec.x_wb && x_wdata == ref_rec.x_wdata))
        else begin errors++; $display("FAILED at %0t: register writeback mismatch", $time); end

    a_csr: assert property (@(posedge clk) disable iff (reset)
        have_rec |-> (csr_wb == ref_rec.csr_wb && csr_wdata == ref_rec.csr_wdata))
        else begin errors++; $display("FAILED at %0t: CSR writeback mismatch", $time); end

    // Nothing emitted yet, so everything still at its reset value
    a_clear: assert property (@(posedge clk) disable iff (reset)
        !have_rec |-> (x_wb == '0 && csr_wb == '0 && order == '0 && !halt))
        else begin errors++; $display("FAILED at %0t: outputs not clear after reset", $time); end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin
        int          errs;
        logic [31:0] r;
        trace_en = 1'b0;
        rvfi_valid = 1'b0;
        rvfi_insn = '0;
        rvfi_pc_rdata = '0;
        rvfi_pc_wdata = '0;
        rvfi_rd_addr = '0;
        rvfi_rd_wdata = '0;
        rvfi_csr_wen = 1'b0;
        rvfi_csr_wdata = '0;
        rvfi_trap = 1'b0;
        rvfi_intr = 1'b0;
        rvfi_halt = 1'b0;
        rvfi_mode = '0;
        lfsr_state  = 32'd98;
        order_cnt   = '0;
        pc_model    = 32'h8000_0000;
        model_state = M_OFF;
        wait (!reset);

        // Tracing off, so these are all dropped
        errs = errors;
        idle_cycles(2);
        repeat (4) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        idle_cycles(1);
        report_test("reset", errs);

        // Random destinations, then an explicit x0 write
        errs = errors;
        trace_en = 1'b1;
        idle_cycles(1);
        repeat (40) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        retire('0, rand_bits(32), 1'b0, 1'b0);
        idle_cycles(1);
        report_test("xreg", errs);

        // Every tracked CSR, one untracked, one with the enable low, then a random mix
        errs = errors;
        for (int i = 0; i < NUM_CSR; i++) begin
            r = rand_bits(20);
            retire(rand_reg(), {TRACKED_CSR[i], r[19:0]}, 1'b1, 1'b0);
        end
        r = rand_bits(20);
        retire(rand_reg(), {12'h340, r[19:0]}, 1'b1, 1'b0);
        r = rand_bits(20);
        retire(rand_reg(), {TRACKED_CSR[5], r[19:0]}, 1'b0, 1'b0);
        repeat (10) begin
            r = rand_bits(24);
            if (r[23:20] < 4'd10) retire(rand_reg(), {TRACKED_CSR[r[23:20]], r[19:0]}, 1'b1, 1'b0);
            else retire(rand_reg(), {8'h7C, r[23:0]}, 1'b1, 1'b0);
        end
        idle_cycles(1);
        report_test("csr", errs);

        // Back to back, with gaps, and across dropped retirements
        errs = errors;
        repeat (5) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        repeat (8) begin
            retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
            r = rand_bits(2);
            idle_cycles(int'(r[1:0]));
        end
        trace_en = 1'b0;
        repeat (2) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        trace_en = 1'b1;
        idle_cycles(1);
        repeat (4) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        idle_cycles(1);
        report_test("order", errs);

        // Halting record, dropped followers, then a disable and re-enable
        errs = errors;
        retire(rand_reg(), rand_bits(32), 1'b0, 1'b1);
        repeat (3) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        trace_en = 1'b0;
        idle_cycles(1);
        trace_en = 1'b1;
        idle_cycles(1);
        repeat (3) retire(rand_reg(), rand_bits(32), 1'b0, 1'b0);
        idle_cycles(3);
        report_test("halt", errs);

        $display("Summary: %0d tests, %0d records checked, %0d errors",
                 tests_run, rec_count, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: rvvi_tracer.f
hdl/trace_pkg.sv
hdl/trace_ctrl_fsm.sv
hdl/retire_order_counter.sv
hdl/retire_record_reg.sv
hdl/csr_writeback_map.sv
hdl/rvvi_tracer.sv
sim/tb_clock_gen.sv
sim/tb_rvvi_tracer.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the tracer testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

TOP=tb_rvvi_tracer
BUILD_DIR=obj_dir
LOG_FILE=sim.log

# Build
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o "$TOP" \
    -f rvvi_tracer.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Run
"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# Verdict from the log
if grep -qx "=== PASS ===" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
